// ==== source/avs_pkg.sv ====
`default_nettype none

package avs_pkg;

    localparam int NUM_BANKS      = 2;
    localparam int BANK_SEL_W     = 1;   // kept >= 1 so the bank field exists
    localparam int DATA_W         = 32;
    localparam int BYTEEN_W       = DATA_W / 8;
    localparam int ADDR_W         = 12;  // word address
    localparam int BANK_ADDR_W    = ADDR_W - BANK_SEL_W;
    localparam int BANK_DEPTH     = 2 ** BANK_ADDR_W;
    localparam int TAG_W          = 6;
    localparam int RD_QUEUE_SIZE  = 4;
    localparam int RD_QUEUE_PTR_W = (RD_QUEUE_SIZE > 1) ? $clog2(RD_QUEUE_SIZE) : 1;
    localparam int RD_QUEUE_CNT_W = $clog2(RD_QUEUE_SIZE + 1);
    localparam int RD_LATENCY     = 3;

    typedef struct packed {
        logic                rw;     // 1 = write
        logic [BYTEEN_W-1:0] byteen;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
        logic [TAG_W-1:0]    tag;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [TAG_W-1:0]  tag;
    } mem_rsp_t;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [BANK_ADDR_W-1:0] address;
        logic [BYTEEN_W-1:0]    byteenable;
        logic [DATA_W-1:0]      writedata;
    } avs_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] readdata;
        logic              readdatavalid;
        logic              waitrequest;
    } avs_rsp_t;

endpackage

`default_nettype wire

// ==== source/fifo_queue.sv ====
`default_nettype none

module fifo_queue
    import avs_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     empty,
    output logic     full
);

    payload_t                  entries_q [RD_QUEUE_SIZE];
    logic [RD_QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [RD_QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [RD_QUEUE_CNT_W-1:0] count_q;
    logic                      do_push;
    logic                      do_pop;

    function automatic logic [RD_QUEUE_PTR_W-1:0] ptr_inc(input logic [RD_QUEUE_PTR_W-1:0] ptr);
        if (ptr == RD_QUEUE_PTR_W'(RD_QUEUE_SIZE - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign empty   = (count_q == '0);
    assign full    = (count_q == RD_QUEUE_CNT_W'(RD_QUEUE_SIZE));
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop); // full queue still takes a push on pop

    assign data_out = entries_q[rd_ptr_q];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            entries_q[wr_ptr_q] <= data_in;
    end

endmodule

`default_nettype wire

// ==== source/stream_arbiter.sv ====
`default_nettype none

module stream_arbiter
    import avs_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [NUM_BANKS-1:0] valid_in,
    input  payload_t             data_in [NUM_BANKS],
    output logic [NUM_BANKS-1:0] ready_in,
    output logic                 valid_out,
    output payload_t             data_out,
    input  logic                 ready_out
);

    logic [BANK_SEL_W-1:0] last_q;    // last input served
    logic [BANK_SEL_W-1:0] grant_idx;
    logic                  grant_valid;

    // search starts one past the last winner
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = last_q;
        for (int i = 1; i <= NUM_BANKS; i++) begin
            idx = (int'(last_q) + i) % NUM_BANKS;
            if (!grant_valid && valid_in[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = BANK_SEL_W'(idx);
            end
        end
    end

    assign valid_out = grant_valid;
    assign data_out  = data_in[grant_idx];

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_ready
        assign ready_in[i] = ready_out && grant_valid && (grant_idx == BANK_SEL_W'(i));
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q <= BANK_SEL_W'(NUM_BANKS - 1); // input 0 first
        end else if (grant_valid && ready_out) begin
            last_q <= grant_idx;
        end
    end

endmodule

`default_nettype wire

// ==== source/avs_bridge.sv ====
`default_nettype none

module avs_bridge
    import avs_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     mem_req_valid,
    input  mem_req_t mem_req,
    output logic     mem_req_ready,

    output logic     mem_rsp_valid,
    output mem_rsp_t mem_rsp,
    input  logic     mem_rsp_ready,

    output avs_req_t avs_req [NUM_BANKS],
    input  avs_rsp_t avs_rsp [NUM_BANKS]
);

    logic [BANK_SEL_W-1:0]  bank_sel;
    logic [BANK_ADDR_W-1:0] bank_addr;
    logic                   rd_accept;

    logic [NUM_BANKS-1:0] tag_full;
    logic [NUM_BANKS-1:0] rd_empty;
    logic [NUM_BANKS-1:0] rsp_pop;
    logic [TAG_W-1:0]     tag_head [NUM_BANKS];
    logic [DATA_W-1:0]    rd_head  [NUM_BANKS];

    logic [NUM_BANKS-1:0] arb_valid_in;
    logic [NUM_BANKS-1:0] arb_ready_in;
    mem_rsp_t             arb_data_in [NUM_BANKS];

    // low address bits pick the bank
    assign bank_sel  = mem_req.addr[BANK_SEL_W-1:0];
    assign bank_addr = mem_req.addr[ADDR_W-1:BANK_SEL_W];

    assign mem_req_ready = !(avs_rsp[bank_sel].waitrequest || tag_full[bank_sel]);
    assign rd_accept     = mem_req_valid && mem_req_ready && !mem_req.rw;

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        logic sel;

        assign sel = (bank_sel == BANK_SEL_W'(i)) && !tag_full[i];

        assign avs_req[i] = '{
            read:       mem_req_valid && !mem_req.rw && sel,
            write:      mem_req_valid && mem_req.rw && sel,
            address:    bank_addr,
            byteenable: mem_req.byteen,
            writedata:  mem_req.data
        };

        // tags of reads in flight, oldest at head
        fifo_queue #(
            .payload_t (logic [TAG_W-1:0])
        ) tag_queue (
            .clk      (clk),
            .arst_n   (arst_n),
            .push     (rd_accept && (bank_sel == BANK_SEL_W'(i))),
            .pop      (rsp_pop[i]),
            .data_in  (mem_req.tag),
            .data_out (tag_head[i]),
            .empty    (),
            .full     (tag_full[i])
        );

        // cannot overflow, each entry already owns a tag
        fifo_queue #(
            .payload_t (logic [DATA_W-1:0])
        ) rd_data_queue (
            .clk      (clk),
            .arst_n   (arst_n),
            .push     (avs_rsp[i].readdatavalid),
            .pop      (rsp_pop[i]),
            .data_in  (avs_rsp[i].readdata),
            .data_out (rd_head[i]),
            .empty    (rd_empty[i]),
            .full     ()
        );

        assign arb_valid_in[i] = !rd_empty[i];
        assign arb_data_in[i]  = '{data: rd_head[i], tag: tag_head[i]};
        assign rsp_pop[i]      = arb_valid_in[i] && arb_ready_in[i]; // both queues pop together
    end

    stream_arbiter #(
        .payload_t (mem_rsp_t)
    ) rsp_arb (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (arb_valid_in),
        .data_in   (arb_data_in),
        .ready_in  (arb_ready_in),
        .valid_out (mem_rsp_valid),
        .data_out  (mem_rsp),
        .ready_out (mem_rsp_ready)
    );

endmodule

`default_nettype wire

// ==== source/avs_bank_mem.sv ====
`default_nettype none

module avs_bank_mem
    import avs_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  avs_req_t avs_req,
    output avs_rsp_t avs_rsp
);

    logic [DATA_W-1:0] mem [BANK_DEPTH];

    logic              wr_recover_q;  // one idle cycle after each write
    logic              rd_accept;
    logic              wr_accept;

    // read pipe, stage 0 samples the array at the accept edge
    logic [RD_LATENCY:0] rd_vld_q;
    logic [DATA_W-1:0]   rd_data_q [RD_LATENCY+1];

    assign rd_accept = avs_req.read && !wr_recover_q;
    assign wr_accept = avs_req.write && !wr_recover_q;

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            for (int b = 0; b < BYTEEN_W; b++) begin
                if (avs_req.byteenable[b])
                    mem[avs_req.address][b*8 +: 8] <= avs_req.writedata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_recover_q <= 1'b0;
            rd_vld_q     <= '0;
        end else begin
            wr_recover_q <= wr_accept;
            rd_vld_q     <= {rd_vld_q[RD_LATENCY-1:0], rd_accept};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept)
            rd_data_q[0] <= mem[avs_req.address]; // old value if written same edge
        for (int s = 1; s <= RD_LATENCY; s++) begin
            rd_data_q[s] <= rd_data_q[s-1];
        end
    end

    assign avs_rsp = '{
        readdata:      rd_data_q[RD_LATENCY],
        readdatavalid: rd_vld_q[RD_LATENCY],
        waitrequest:   wr_recover_q
    };

endmodule

`default_nettype wire

// ==== source/avs_mem_subsys.sv ====
`default_nettype none

module avs_mem_subsys
    import avs_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     mem_req_valid,
    input  mem_req_t mem_req,
    output logic     mem_req_ready,

    output logic     mem_rsp_valid,
    output mem_rsp_t mem_rsp,
    input  logic     mem_rsp_ready
);

    avs_req_t avs_req [NUM_BANKS];
    avs_rsp_t avs_rsp [NUM_BANKS];

    avs_bridge bridge_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .avs_req       (avs_req),
        .avs_rsp       (avs_rsp)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        avs_bank_mem bank_i (
            .clk     (clk),
            .arst_n  (arst_n),
            .avs_req (avs_req[i]),
            .avs_rsp (avs_rsp[i])
        );
    end

endmodule

`default_nettype wire

// ==== verif/avs_mem_tb.sv ====
`default_nettype none

module avs_mem_tb
    import avs_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TAGS        = 2 ** TAG_W;
    localparam int TOTAL_REQS      = 4 + 12 + 32 + 12 + 200;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + 500;
    localparam int REQ_TIMEOUT     = 200;
    localparam int DRAIN_TIMEOUT   = 500;
    localparam int RSP_ALWAYS      = 0;
    localparam int RSP_HOLD        = 1;
    localparam int RSP_RANDOM      = 2;

    logic     clk;
    logic     arst_n;
    logic     mem_req_valid;
    mem_req_t mem_req;
    logic     mem_req_ready;
    logic     mem_rsp_valid;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_ready;

    // reference model and scoreboard
    logic [DATA_W-1:0] ref_mem [int];
    bit                outstanding [NUM_TAGS];
    logic [DATA_W-1:0] exp_data [NUM_TAGS];
    int                exp_bank [NUM_TAGS];
    int                exp_seq  [NUM_TAGS];   // position within its bank
    int                issue_cnt [NUM_BANKS];
    int                ret_cnt   [NUM_BANKS];
    int                pending = 0;
    logic [TAG_W-1:0]  next_tag = '0;

    int     mismatch_cnt = 0;
    int     fail_cnt     = 0;
    string  cur_test     = "none";
    int     rsp_mode     = RSP_ALWAYS;
    integer seed         = 8262;
    integer stall_seed   = 8262 + 1;

    avs_mem_subsys dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s (%s): expected %h, actual %h",
                     cur_test, what, expected, actual);
            mismatch_cnt++;
        end
    endtask

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [BYTEEN_W-1:0] be);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < BYTEEN_W; b++) begin
            if (be[b])
                res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr ^ 12'h5a3, 8'h3c, addr};
    endfunction

    function automatic int bank_of(input logic [ADDR_W-1:0] addr);
        return int'(addr[BANK_SEL_W-1:0]);
    endfunction

    // next tag not held by a read in flight
    function automatic logic [TAG_W-1:0] alloc_tag();
        logic [TAG_W-1:0] t;
        t = next_tag;
        for (int n = 0; n < NUM_TAGS && outstanding[t]; n++)
            t++;
        next_tag = t + 1'b1;
        return t;
    endfunction

    // starts and returns 1 ns after a rising edge
    task automatic send_req(input mem_req_t req);
        int waited;
        int bank;
        bit accepted;
        logic [DATA_W-1:0] old_w;
        waited        = 0;
        mem_req       = req;
        mem_req_valid = 1'b1;
        @(negedge clk);
        while (!mem_req_ready && waited < REQ_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        accepted = mem_req_ready;
        if (!accepted) begin
            $display("%s: request to address %h was not accepted within %0d cycles",
                     cur_test, req.addr, REQ_TIMEOUT);
            fail_cnt++;
        end
        @(posedge clk);
        #1;
        mem_req_valid = 1'b0;
        if (accepted) begin
            bank = bank_of(req.addr);
            if (req.rw) begin
                old_w = ref_mem.exists(int'(req.addr)) ? ref_mem[int'(req.addr)] : 'x;
                ref_mem[int'(req.addr)] = merge_bytes(old_w, req.data, req.byteen);
            end else begin
                outstanding[req.tag] = 1'b1;
                exp_data[req.tag]    = ref_mem[int'(req.addr)];
                exp_bank[req.tag]    = bank;
                exp_seq[req.tag]     = issue_cnt[bank];
                issue_cnt[bank]++;
                pending++;
            end
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [BYTEEN_W-1:0] be);
        mem_req_t req;
        req = '{rw: 1'b1, byteen: be, addr: addr, data: data, tag: '0};
        send_req(req);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr);
        mem_req_t req;
        req = '{rw: 1'b0, byteen: '1, addr: addr, data: '0, tag: alloc_tag()};
        send_req(req);
    endtask

    task automatic take_rsp(input mem_rsp_t rsp);
        int bank;
        if (!outstanding[rsp.tag]) begin
            $display("%s: response with unknown or repeated tag %0d", cur_test, rsp.tag);
            fail_cnt++;
        end else begin
            bank = exp_bank[rsp.tag];
            check($sformatf("read data, tag %0d", rsp.tag), exp_data[rsp.tag], rsp.data);
            check($sformatf("bank %0d order, tag %0d", bank, rsp.tag),
                  exp_seq[rsp.tag], ret_cnt[bank]);
            ret_cnt[bank]++;
            outstanding[rsp.tag] = 1'b0;
            pending--;
        end
    endtask

    // transfer completes at the next rising edge
    initial begin
        forever begin
            @(negedge clk);
            if (arst_n && mem_rsp_valid && mem_rsp_ready)
                take_rsp(mem_rsp);
        end
    end

    // mode taken at the edge, applies from this cycle on
    initial begin
        int mode;
        forever begin
            @(posedge clk);
            mode = rsp_mode;
            #1;
            case (mode)
                RSP_HOLD:   mem_rsp_ready = 1'b0;
                RSP_RANDOM: mem_rsp_ready = (($random(stall_seed) & 3) != 0);
                default:    mem_rsp_ready = 1'b1;
            endcase
        end
    end

    task automatic collect_rsp(input bit random_stall);
        int waited;
        waited   = 0;
        rsp_mode = random_stall ? RSP_RANDOM : RSP_ALWAYS;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pending != 0) begin
            $display("%s: %0d read response(s) missing", cur_test, pending);
            fail_cnt++;
            for (int t = 0; t < NUM_TAGS; t++)
                outstanding[t] = 1'b0;
            for (int b = 0; b < NUM_BANKS; b++)
                ret_cnt[b] = issue_cnt[b];
            pending = 0;
        end
        rsp_mode = RSP_ALWAYS;
    endtask

    task automatic test_reset();
        cur_test = "test_reset";
        @(negedge clk);
        check("mem_rsp_valid", 1'b0, mem_rsp_valid);
        check("mem_req_ready", 1'b1, mem_req_ready);
        @(posedge clk);
        #1;
    endtask

    task automatic test_write_read();
        logic [ADDR_W-1:0] addr;
        cur_test = "test_write_read";
        for (int b = 0; b < NUM_BANKS; b++) begin
            addr = 12'h040 | ADDR_W'(b);
            write_word(addr, fill_word(addr), '1);
            read_word(addr);
        end
        collect_rsp(1'b0);
    endtask

    task automatic test_byteen();
        logic [ADDR_W-1:0] addr;
        cur_test = "test_byteen";
        for (int b = 0; b < NUM_BANKS; b++) begin
            addr = 12'h080 | ADDR_W'(b);
            write_word(addr, 32'h11223344, 4'b1111);
            write_word(addr, 32'haaaaaaaa, 4'b0001);
            read_word(addr);
            write_word(addr, 32'hbbbbbbbb, 4'b0110);
            read_word(addr);
            write_word(addr, 32'hcccccccc, 4'b1000);
            read_word(addr);
        end
        collect_rsp(1'b0);
    endtask

    task automatic test_interleave();
        cur_test = "test_interleave";
        for (int i = 0; i < 16; i++)
            write_word(12'h100 + ADDR_W'(i), fill_word(12'h100 + ADDR_W'(i)), '1);
        for (int i = 0; i < 16; i++)
            read_word(12'h100 + ADDR_W'(i));   // banks alternate
        collect_rsp(1'b0);
    endtask

    task automatic test_backpressure();
        mem_req_t req;
        cur_test = "test_backpressure";
        for (int i = 0; i < 6; i++)
            write_word(12'h300 + ADDR_W'(2 * i), fill_word(12'h300 + ADDR_W'(2 * i)), '1);
        rsp_mode = RSP_HOLD;
        @(posedge clk);
        #1;
        for (int i = 0; i < RD_QUEUE_SIZE; i++)
            read_word(12'h300 + ADDR_W'(2 * i));
        req = '{rw: 1'b0, byteen: '1, addr: 12'h308, data: '0, tag: alloc_tag()};
        mem_req       = req;
        mem_req_valid = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check("mem_req_ready with full tag queue", 1'b0, mem_req_ready);
        end
        @(posedge clk);
        #1;
        rsp_mode = RSP_ALWAYS;
        send_req(req);
        read_word(12'h30a);
        collect_rsp(1'b0);
    endtask

    task automatic test_random();
        logic [ADDR_W-1:0]   addr;
        logic [BYTEEN_W-1:0] be;
        logic [DATA_W-1:0]   data;
        bit                  do_write;
        cur_test = "test_random";
        rsp_mode = RSP_RANDOM;
        for (int n = 0; n < 200; n++) begin
            addr     = 12'h200 + ADDR_W'($random(seed) & 31);
            do_write = ($random(seed) & 1) != 0;
            be       = BYTEEN_W'($random(seed));
            data     = $random(seed);
            if (!ref_mem.exists(int'(addr)))
                write_word(addr, data, '1);   // first touch fills the whole word
            else if (do_write)
                write_word(addr, data, be);
            else
                read_word(addr);
        end
        collect_rsp(1'b1);
        @(negedge clk);
        check("mem_rsp_valid after drain", 1'b0, mem_rsp_valid);
        @(posedge clk);
        #1;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        arst_n        = 1'b0;
        mem_req_valid = 1'b0;
        mem_req       = '0;
        mem_rsp_ready = 1'b1;
        for (int b = 0; b < NUM_BANKS; b++) begin
            issue_cnt[b] = 0;
            ret_cnt[b]   = 0;
        end
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset();
        test_write_read();
        test_byteen();
        test_interleave();
        test_backpressure();
        test_random();

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/avs_pkg.sv
source/fifo_queue.sv
source/stream_arbiter.sv
source/avs_bridge.sv
source/avs_bank_mem.sv
source/avs_mem_subsys.sv
verif/avs_mem_tb.sv
